// File: src/issue_pkg.sv
package issue_pkg;

	// architectural register file
	parameter int NUM_REGS = 32;
	parameter int REG_ADDR_W = $clog2(NUM_REGS);

	// register number, 0 stands for no register
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// how the raw field maps onto register numbers
	typedef logic [2:0] reg_type_t;

	// low part of the instruction word
	typedef logic [25:0] inst_field_t;

	// one bit per source operand
	typedef logic [1:0] use_time_t;

	// stage in which a result first exists
	typedef logic [1:0] ready_time_t;

	// bit 0 ex, bit 1 m1, bit 2 m2
	typedef logic [2:0] stage_vec_t;

	// register-type codes, code 7 is unused and decodes to no registers
	parameter reg_type_t REG_TYPE_I = 3'd0;
	parameter reg_type_t REG_TYPE_RW = 3'd1;
	parameter reg_type_t REG_TYPE_RRW = 3'd2;
	parameter reg_type_t REG_TYPE_BL = 3'd3;
	parameter reg_type_t REG_TYPE_RR = 3'd4;
	parameter reg_type_t REG_TYPE_CSRXCHG = 3'd5;
	parameter reg_type_t REG_TYPE_RDCNTID = 3'd6;

	// per-source use time
	parameter logic USE_EX = 1'b0;
	parameter logic USE_M2 = 1'b1;

	// result ready stage
	parameter ready_time_t READY_EX = 2'd0;
	parameter ready_time_t READY_M1 = 2'd1;
	parameter ready_time_t READY_M2 = 2'd2;

	// link register written by BL
	parameter reg_addr_t LINK_REG = 5'd1;

endpackage

// File: src/slot_if.sv
`timescale 1ns/100ps

interface slot_if;

	// two decoded slots, index 0 is older in program order
	logic [1:0] valid;
	issue_pkg::reg_addr_t [1:0] r_reg0;
	issue_pkg::reg_addr_t [1:0] r_reg1;
	issue_pkg::reg_addr_t [1:0] w_reg;
	issue_pkg::use_time_t [1:0] use_time;
	issue_pkg::ready_time_t [1:0] ready_time;
	// pipe_one: pipe 0 only, pipe_two: pipe 1 only
	logic [1:0] pipe_one;
	logic [1:0] pipe_two;

	modport producer (
		output valid, r_reg0, r_reg1, w_reg, use_time, ready_time, pipe_one, pipe_two
	);

	modport consumer (
		input valid, r_reg0, r_reg1, w_reg, use_time, ready_time, pipe_one, pipe_two
	);

endinterface

// File: src/reg_extract.sv
`timescale 1ns/100ps

module reg_extract (
	// clock and reset only serve bound checkers, the decode is combinational
	input  logic clk,
	input  logic rst_n,
	input  issue_pkg::reg_type_t [1:0] reg_type_i,
	input  issue_pkg::inst_field_t [1:0] field_i,
	input  issue_pkg::use_time_t [1:0] use_time_i,
	input  issue_pkg::ready_time_t [1:0] ready_time_i,
	input  logic [1:0] pipe_one_i,
	input  logic [1:0] pipe_two_i,
	input  logic [1:0] inst_valid_i,
	slot_if.producer slots_o
);

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			slots_o.r_reg0[s] = '0;
			slots_o.r_reg1[s] = '0;
			slots_o.w_reg[s] = '0;
			case (reg_type_i[s])
				issue_pkg::REG_TYPE_RW: begin
					slots_o.r_reg1[s] = field_i[s][9:5];
					slots_o.w_reg[s] = field_i[s][4:0];
				end
				issue_pkg::REG_TYPE_RRW: begin
					slots_o.r_reg0[s] = field_i[s][14:10];
					slots_o.r_reg1[s] = field_i[s][9:5];
					slots_o.w_reg[s] = field_i[s][4:0];
				end
				issue_pkg::REG_TYPE_BL: begin
					slots_o.w_reg[s] = issue_pkg::LINK_REG;
				end
				issue_pkg::REG_TYPE_RR: begin
					slots_o.r_reg0[s] = field_i[s][4:0];
					slots_o.r_reg1[s] = field_i[s][9:5];
				end
				// rd is both read and written
				issue_pkg::REG_TYPE_CSRXCHG: begin
					slots_o.r_reg0[s] = field_i[s][4:0];
					slots_o.w_reg[s] = field_i[s][4:0];
				end
				issue_pkg::REG_TYPE_RDCNTID: begin
					slots_o.w_reg[s] = field_i[s][9:5];
				end
				// REG_TYPE_I and unused codes touch no register
				default: begin
				end
			endcase
		end
	end

	// younger slot only counts behind a valid older one
	assign slots_o.valid = {inst_valid_i[1] & inst_valid_i[0], inst_valid_i[0]};

	assign slots_o.use_time = use_time_i;
	assign slots_o.ready_time = ready_time_i;
	assign slots_o.pipe_one = pipe_one_i;
	assign slots_o.pipe_two = pipe_two_i;

endmodule

// File: src/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl #(
	parameter int SB_ENTRIES = issue_pkg::NUM_REGS
) (
	input  logic clk,
	input  logic rst_n,
	slot_if.consumer slots_i,
	input  logic stall_i,
	input  logic clr_frontend_i,
	input  issue_pkg::stage_vec_t [1:0] stall_vec_i,
	input  issue_pkg::stage_vec_t [1:0] clr_vec_i,
	output logic [1:0] issue_o,
	output logic revert_o
);

	// one producer in flight per register, pos == 0 means free
	typedef struct packed {
		logic pipe_sel;
		issue_pkg::stage_vec_t pos;
		logic fwd;
		issue_pkg::ready_time_t ready;
	} sb_entry_t;

	// register 0 never has an entry
	sb_entry_t [SB_ENTRIES-1:1] sb_q;
	sb_entry_t [SB_ENTRIES-1:1] sb_d;

	logic [1:0] raw_hit;
	logic pair_data;
	logic pair_ctrl;
	logic issue0;
	logic issue1;

	function automatic logic src_conflict(
		input sb_entry_t [SB_ENTRIES-1:1] sb,
		input issue_pkg::reg_addr_t src,
		input logic use_t
	);
		sb_entry_t e;
		logic reached;
		logic hit;
		e = '0;
		hit = 1'b0;
		if (src != '0 && int'(src) < SB_ENTRIES) begin
			e = sb[src];
		end
		// producer has reached its ready stage, P >= R
		reached = ((e.ready == issue_pkg::READY_EX) && (|e.pos)) ||
			((e.ready == issue_pkg::READY_M1) && (|e.pos[2:1])) ||
			((e.ready == issue_pkg::READY_M2) && e.pos[2]);
		if (e.pos != '0) begin
			if (use_t == issue_pkg::USE_EX) begin
				hit = !(e.fwd && reached);
			end else if (use_t == issue_pkg::USE_M2) begin
				// an m2 consumer only misses a producer still in ex that is ready in m2
				hit = !e.fwd || (e.pos[0] && e.ready == issue_pkg::READY_M2);
			end
		end
		return hit;
	endfunction

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			raw_hit[s] = src_conflict(sb_q, slots_i.r_reg0[s], slots_i.use_time[s][0]) ||
				src_conflict(sb_q, slots_i.r_reg1[s], slots_i.use_time[s][1]);
		end
	end

	// slot 1 may not touch what slot 0 writes
	assign pair_data = (slots_i.w_reg[0] != '0) &&
		((slots_i.w_reg[0] == slots_i.r_reg0[1]) ||
		(slots_i.w_reg[0] == slots_i.r_reg1[1]) ||
		(slots_i.w_reg[0] == slots_i.w_reg[1]));

	// only one pipe runs load/store, CSR and branch work
	assign pair_ctrl = slots_i.pipe_one[0] & slots_i.pipe_one[1];

	assign issue0 = slots_i.valid[0] & ~stall_i & ~clr_frontend_i & ~raw_hit[0];
	assign issue1 = issue0 & slots_i.valid[1] & ~raw_hit[1] & ~pair_data & ~pair_ctrl;

	assign issue_o = {issue1, issue0};
	assign revert_o = (issue1 & slots_i.pipe_one[1]) | (issue0 & slots_i.pipe_two[0]);

	always_comb begin
		for (int r = 1; r < SB_ENTRIES; r++) begin
			sb_d[r] = sb_q[r];
			// stall beats clear on the same stage
			if (!(|(sb_q[r].pos & stall_vec_i[sb_q[r].pipe_sel]))) begin
				sb_d[r].pos = {sb_q[r].pos[1:0], 1'b0};
				if (|(sb_q[r].pos & clr_vec_i[sb_q[r].pipe_sel])) begin
					sb_d[r].fwd = 1'b0;
				end
			end
			// new producer wins over everything
			for (int s = 0; s < 2; s++) begin
				if (issue_o[s] && slots_i.w_reg[s] == issue_pkg::reg_addr_t'(r)) begin
					sb_d[r].pipe_sel = (s == 1) ^ revert_o;
					sb_d[r].pos = 3'b001;
					sb_d[r].fwd = 1'b1;
					sb_d[r].ready = slots_i.ready_time[s];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb_q <= '0;
		end else begin
			sb_q <= sb_d;
		end
	end

endmodule

// File: src/pipe_dispatch.sv
`timescale 1ns/100ps

module pipe_dispatch (
	input  logic clk,
	input  logic rst_n,
	slot_if.consumer slots_i,
	input  logic [1:0] issue_i,
	input  logic revert_i,
	input  issue_pkg::stage_vec_t [1:0] stall_vec_i,
	input  issue_pkg::stage_vec_t [1:0] clr_vec_i,
	output logic [1:0] pipe_valid_o,
	output issue_pkg::reg_addr_t [1:0] pipe_wreg_o,
	output logic [1:0] pipe_slot_o
);

	// slot feeding each pipe this cycle
	logic [1:0] in_slot;
	logic [1:0] in_valid;
	issue_pkg::reg_addr_t [1:0] in_wreg;

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			in_slot[p] = (p == 1) ^ revert_i;
			in_valid[p] = issue_i[in_slot[p]];
			in_wreg[p] = slots_i.w_reg[in_slot[p]];
		end
	end

	for (genvar p = 0; p < 2; p++) begin : g_ex
		// ex stage valid, a stall holds it and a clear empties it
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				pipe_valid_o[p] <= 1'b0;
			end else if (!stall_vec_i[p][0]) begin
				pipe_valid_o[p] <= in_valid[p] & ~clr_vec_i[p][0];
			end
		end

		always_ff @(posedge clk) begin
			if (!stall_vec_i[p][0]) begin
				pipe_wreg_o[p] <= in_wreg[p];
				pipe_slot_o[p] <= in_slot[p];
			end
		end
	end

endmodule

// File: src/issue_top.sv
`timescale 1ns/100ps

module issue_top #(
	parameter int SB_ENTRIES = issue_pkg::NUM_REGS
) (
	input  logic clk,
	input  logic rst_n,
	input  issue_pkg::reg_type_t [1:0] reg_type_i,
	input  issue_pkg::inst_field_t [1:0] field_i,
	input  issue_pkg::use_time_t [1:0] use_time_i,
	input  issue_pkg::ready_time_t [1:0] ready_time_i,
	input  logic [1:0] pipe_one_i,
	input  logic [1:0] pipe_two_i,
	input  logic [1:0] inst_valid_i,
	input  logic stall_i,
	input  logic clr_frontend_i,
	input  issue_pkg::stage_vec_t [1:0] stall_vec_i,
	input  issue_pkg::stage_vec_t [1:0] clr_vec_i,
	output logic [1:0] issue_o,
	output logic revert_o,
	output logic [1:0] pipe_valid_o,
	output issue_pkg::reg_addr_t [1:0] pipe_wreg_o,
	output logic [1:0] pipe_slot_o
);

	slot_if u_slots ();

	reg_extract u_reg_extract (
		.clk          (clk),
		.rst_n        (rst_n),
		.reg_type_i   (reg_type_i),
		.field_i      (field_i),
		.use_time_i   (use_time_i),
		.ready_time_i (ready_time_i),
		.pipe_one_i   (pipe_one_i),
		.pipe_two_i   (pipe_two_i),
		.inst_valid_i (inst_valid_i),
		.slots_o      (u_slots.producer)
	);

	issue_ctrl #(
		.SB_ENTRIES (SB_ENTRIES)
	) u_issue_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.slots_i        (u_slots.consumer),
		.stall_i        (stall_i),
		.clr_frontend_i (clr_frontend_i),
		.stall_vec_i    (stall_vec_i),
		.clr_vec_i      (clr_vec_i),
		.issue_o        (issue_o),
		.revert_o       (revert_o)
	);

	pipe_dispatch u_pipe_dispatch (
		.clk          (clk),
		.rst_n        (rst_n),
		.slots_i      (u_slots.consumer),
		.issue_i      (issue_o),
		.revert_i     (revert_o),
		.stall_vec_i  (stall_vec_i),
		.clr_vec_i    (clr_vec_i),
		.pipe_valid_o (pipe_valid_o),
		.pipe_wreg_o  (pipe_wreg_o),
		.pipe_slot_o  (pipe_slot_o)
	);

endmodule

// File: verif/issue_asserts.sv
`timescale 1ns/100ps

module issue_asserts (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] issue_i,
	input  logic revert_i,
	input  logic stall_i,
	input  logic clr_frontend_i
);

	// issue is strictly in order
	a_in_order: assert property (@(posedge clk) disable iff (!rst_n) issue_i != 2'b10)
		else $error("slot 1 issued without slot 0");

	a_revert_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
		revert_i |-> (issue_i != 2'b00))
		else $error("revert raised with nothing issued");

	// front end hold or flush blocks the whole pair
	a_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		(stall_i || clr_frontend_i) |-> (issue_i == 2'b00))
		else $error("issue while stall or front end clear is high");

endmodule

// File: verif/issue_tb.sv
`timescale 1ns/100ps

module issue_tb;

	localparam int NCOL = 21;
	localparam int NROWS = 43;
	localparam int RESET_TIMEOUT = 100;

	logic clk;
	logic rst_n;
	issue_pkg::reg_type_t [1:0] reg_type_i;
	issue_pkg::inst_field_t [1:0] field_i;
	issue_pkg::use_time_t [1:0] use_time_i;
	issue_pkg::ready_time_t [1:0] ready_time_i;
	logic [1:0] pipe_one_i;
	logic [1:0] pipe_two_i;
	logic [1:0] inst_valid_i;
	logic stall_i;
	logic clr_frontend_i;
	issue_pkg::stage_vec_t [1:0] stall_vec_i;
	issue_pkg::stage_vec_t [1:0] clr_vec_i;
	logic [1:0] issue_o;
	logic revert_o;
	logic [1:0] pipe_valid_o;
	issue_pkg::reg_addr_t [1:0] pipe_wreg_o;
	logic [1:0] pipe_slot_o;

	logic [31:0] vec [0:NCOL*NROWS-1];
	int errors;
	int checks;
	int test_errs;
	int test_checks;

	issue_top #(
		.SB_ENTRIES (32)
	) u_issue_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.reg_type_i     (reg_type_i),
		.field_i        (field_i),
		.use_time_i     (use_time_i),
		.ready_time_i   (ready_time_i),
		.pipe_one_i     (pipe_one_i),
		.pipe_two_i     (pipe_two_i),
		.inst_valid_i   (inst_valid_i),
		.stall_i        (stall_i),
		.clr_frontend_i (clr_frontend_i),
		.stall_vec_i    (stall_vec_i),
		.clr_vec_i      (clr_vec_i),
		.issue_o        (issue_o),
		.revert_o       (revert_o),
		.pipe_valid_o   (pipe_valid_o),
		.pipe_wreg_o    (pipe_wreg_o),
		.pipe_slot_o    (pipe_slot_o)
	);

	bind issue_ctrl issue_asserts u_issue_asserts (
		.clk            (clk),
		.rst_n          (rst_n),
		.issue_i        (issue_o),
		.revert_i       (revert_o),
		.stall_i        (stall_i),
		.clr_frontend_i (clr_frontend_i)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] col(input int r, input int c);
		return vec[r*NCOL+c];
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic apply_row(input int r);
		reg_type_i[0] = issue_pkg::reg_type_t'(col(r, 1));
		field_i[0] = issue_pkg::inst_field_t'(col(r, 2));
		reg_type_i[1] = issue_pkg::reg_type_t'(col(r, 3));
		field_i[1] = issue_pkg::inst_field_t'(col(r, 4));
		use_time_i[0] = issue_pkg::use_time_t'(col(r, 5));
		use_time_i[1] = issue_pkg::use_time_t'(col(r, 6));
		ready_time_i[0] = issue_pkg::ready_time_t'(col(r, 7));
		ready_time_i[1] = issue_pkg::ready_time_t'(col(r, 8));
		pipe_one_i = 2'(col(r, 9));
		pipe_two_i = 2'(col(r, 10));
		inst_valid_i = 2'(col(r, 11));
		stall_i = 1'(col(r, 12));
		clr_frontend_i = 1'(col(r, 13));
		stall_vec_i = 6'(col(r, 14));
		clr_vec_i = 6'(col(r, 15));
	endtask

	// pipe outputs only carry meaning where the pipe is valid
	task automatic check_pipes(input int r);
		logic [31:0] exp_valid;
		exp_valid = col(r, 18);
		check_val("pipe_valid_o", 32'(pipe_valid_o), exp_valid);
		for (int p = 0; p < 2; p++) begin
			if (exp_valid[p]) begin
				check_val($sformatf("pipe_wreg_o[%0d]", p), 32'(pipe_wreg_o[p]),
					(col(r, 19) >> (5 * p)) & 32'h1f);
				check_val($sformatf("pipe_slot_o[%0d]", p), 32'(pipe_slot_o[p]),
					(col(r, 20) >> p) & 32'h1);
			end
		end
	endtask

	// reset release on a falling edge
	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
	end

	initial begin
		int fd;
		int wait_cycles;
		bit data_ok;
		logic [31:0] cur_test;
		reg_type_i = '0;
		field_i = '0;
		use_time_i = '0;
		ready_time_i = '0;
		pipe_one_i = '0;
		pipe_two_i = '0;
		inst_valid_i = '0;
		stall_i = 1'b0;
		clr_frontend_i = 1'b0;
		stall_vec_i = '0;
		clr_vec_i = '0;
		errors = 0;
		checks = 0;
		test_errs = 0;
		test_checks = 0;
		data_ok = 1'b1;
		for (int i = 0; i < NCOL * NROWS; i++) begin
			vec[i] = 32'hffff_ffff;
		end
		fd = $fopen("verif/issue_input.txt", "r");
		if (fd == 0) begin
			$display("input data file verif/issue_input.txt could not be opened");
			data_ok = 1'b0;
		end else begin
			$fclose(fd);
			$readmemh("verif/issue_input.txt", vec);
			if (col(NROWS - 1, NCOL - 1) === 32'hffff_ffff) begin
				$display("input data file holds fewer rows than the %0d expected", NROWS);
				data_ok = 1'b0;
			end
		end
		if (!data_ok) begin
			errors++;
		end
		wait_cycles = 0;
		while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout while waiting for reset release");
			$display("ERRORS FOUND");
			$finish;
		end else begin
			if (data_ok) begin
				cur_test = col(0, 0);
				for (int r = 0; r < NROWS; r++) begin
					@(negedge clk);
					apply_row(r);
					#2;
					check_val("issue_o", 32'(issue_o), col(r, 16));
					check_val("revert_o", 32'(revert_o), col(r, 17));
					// ex registers settle well before the next falling edge
					@(posedge clk);
					#2;
					check_pipes(r);
					if (r == NROWS - 1 || col(r + 1, 0) != cur_test) begin
						$display("test %0d: %0d checks, %0d errors", cur_test, test_checks,
							test_errs);
						test_checks = 0;
						test_errs = 0;
						if (r < NROWS - 1) begin
							cur_test = col(r + 1, 0);
						end
					end
				end
			end
			$display("done: %0d checks, %0d errors", checks, errors);
			if (errors == 0) begin
				$display("NO ERRORS");
			end else begin
				$display("ERRORS FOUND");
			end
			$finish;
		end
	end

endmodule

// File: verif/issue_input.txt
// tst t0 f0 t1 f1 u0 u1 r0 r1 p1 p2 vld stall clrfe svec cvec | exp issue revert pvalid
// pwreg ({pipe1,pipe0} 5 bits each) pslot ({pipe1,pipe0}), pipe values one clock later
1 1 0083 2 1cc5 0 0 0 0 0 0 3 0 0 00 00 3 0 3 0a3 2
1 3 0000 6 0120 0 0 0 0 0 0 3 0 0 00 00 3 0 3 121 2
1 5 0003 0 0000 0 0 0 0 0 0 3 0 0 00 00 3 0 3 003 2
1 7 1cc5 4 0125 0 0 0 0 0 0 3 0 0 00 00 3 0 3 000 2
2 1 000a 4 000a 0 0 0 0 0 0 3 0 0 00 00 1 0 1 00a 2
2 1 000b 6 0160 0 0 0 0 0 0 3 0 0 00 00 1 0 1 00b 2
2 1 000c 1 000d 0 0 0 0 3 0 3 0 0 00 00 1 0 1 00c 2
2 1 000e 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 00e 2
2 1 000f 1 000f 0 0 0 0 0 0 2 0 0 00 00 0 0 0 000 2
3 0 0000 0 0000 0 0 0 0 0 0 0 0 0 00 00 0 0 0 000 2
3 0 0000 0 0000 0 0 0 0 0 0 0 0 0 00 00 0 0 0 000 2
3 0 0000 0 0000 0 0 0 0 0 0 0 0 0 00 00 0 0 0 000 2
3 1 0014 0 0000 0 0 1 0 0 0 1 0 0 00 00 1 0 1 014 2
3 4 0014 0 0000 0 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
3 4 0014 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
3 1 0015 0 0000 0 0 2 0 0 0 1 0 0 00 00 1 0 1 015 2
3 4 0015 0 0000 0 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
3 4 0015 0 0000 0 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
3 4 0015 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
3 1 0016 0 0000 0 0 2 0 0 0 1 0 0 00 00 1 0 1 016 2
3 4 0016 0 0000 1 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
3 4 0016 0 0000 1 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
3 1 0017 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 017 2
3 4 0017 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
4 1 0018 1 0019 0 0 0 0 0 1 3 0 0 00 00 3 1 3 319 1
4 1 001a 1 001b 0 0 0 0 2 0 3 0 0 00 00 3 1 3 35b 1
4 1 001c 0 0000 0 0 0 0 0 1 1 0 0 00 00 1 1 2 380 1
4 1 001d 1 001e 0 0 0 0 1 2 3 0 0 00 00 3 0 3 3dd 2
5 1 0002 0 0000 0 0 0 0 0 0 1 1 0 00 00 0 0 0 000 2
5 1 0002 0 0000 0 0 0 0 0 0 1 0 1 00 00 0 0 0 000 2
5 1 0002 0 0000 0 0 1 0 0 0 1 0 0 00 00 1 0 1 002 2
5 4 0002 0 0000 0 0 0 0 0 0 1 0 0 01 00 0 0 1 002 2
5 4 0002 0 0000 0 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
5 4 0002 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
5 1 0004 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 004 2
5 0 0000 0 0000 0 0 0 0 0 0 0 0 0 00 01 0 0 0 000 2
5 4 0004 0 0000 0 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
5 4 0004 0 0000 0 0 0 0 0 0 1 0 0 00 00 0 0 0 000 2
5 4 0004 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
5 1 0006 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 006 2
5 0 0000 0 0000 0 0 0 0 0 0 0 0 0 01 01 0 0 1 006 2
5 4 0006 0 0000 0 0 0 0 0 0 1 0 0 00 00 1 0 1 000 2
5 1 0007 0 0000 0 0 0 0 0 0 1 0 0 00 01 1 0 0 000 2

// File: filelist.f
src/issue_pkg.sv
src/slot_if.sv
src/reg_extract.sv
src/issue_ctrl.sv
src/pipe_dispatch.sv
src/issue_top.sv
verif/issue_asserts.sv
verif/issue_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module issue_tb -Mdir obj_dir

run: compile
	./obj_dir/Vissue_tb > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then exit 1; fi
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
